//--- hdl/irqController.sv
// Interrupt pending flags for timer and vblank requests, cleared by CPU acknowledge
`timescale 1ns/1ps

module irqController import lspcPkg::*; (
	input logic lspc6M,
	input logic rst,
	input logic timerZero,
	input logic irqEnable,
	input rasterPos_t pos,
	input irqAck_t ack,
	output logic irqTimer,
	output logic irqVblank
);

	// Timer request needs the enable bit
	logic timerSet;

	assign timerSet = timerZero && irqEnable;

	// Timer pending flag
	always_ff @(posedge lspc6M) begin
		if (rst) begin
			irqTimer <= 1'b0;
		end else if (timerSet) begin
			// Set wins over a same-cycle ack
			irqTimer <= 1'b1;
		end else if (ack.timer) begin
			irqTimer <= 1'b0;
		end
	end

	// Vblank pending flag, always enabled
	always_ff @(posedge lspc6M) begin
		if (rst) begin
			irqVblank <= 1'b0;
		end else if (pos.vblankStart) begin
			irqVblank <= 1'b1;
		end else if (ack.vblank) begin
			irqVblank <= 1'b0;
		end
	end

	// Vblank irq rises one pixel into the blank line
	assertVblankRise: assert property (
		@(posedge lspc6M) disable iff (rst)
		$rose(irqVblank) |-> (pos.pixel == 9'd1)
	) else $error("irqVblank rose away from pixel 1");

endmodule

//--- hdl/lspcPkg.sv
// Packed bundle types passed between the raster timer blocks, imported by each module header
package lspcPkg;

	// One CPU write cycle
	typedef struct packed {
		// Write strobe, valid for this cycle only
		logic wr;
		// Word address
		logic [2:0] addr;
		logic [15:0] data;
	} cpuWrite_t;

	// Timer control word
	typedef struct packed {
		// Reload when the lower half is written
		logic reloadOnWrite;
		// Reload at vertical blank start
		logic reloadOnVblank;
		// Reload on underflow, repeat mode
		logic reloadOnZero;
		// Pause in border lines, PAL only
		logic stopInBorder;
		logic irqEnable;
	} timerCtrl_t;

	// Current beam position
	typedef struct packed {
		logic [8:0] pixel;
		logic [8:0] line;
		// One cycle pulse at line VBLANK_LINE, pixel 0
		logic vblankStart;
	} rasterPos_t;

	// Acknowledge pulses from the CPU
	typedef struct packed {
		logic timer;
		logic vblank;
	} irqAck_t;

endpackage

//--- hdl/lspcRegs.sv
// CPU register decoder, turns write strobes into timer reload, control and acknowledge outputs
`timescale 1ns/1ps
`include "lspc_settings.svh"

module lspcRegs import lspcPkg::*; (
	input logic lspc6M,
	input logic rst,
	input cpuWrite_t cpuWr,
	output logic [31:0] reloadValue,
	output logic reloadStrobe,
	output timerCtrl_t ctrl,
	output irqAck_t ack
);

	// Timer reload halves
	logic [15:0] timerHigh;
	logic [15:0] timerLow;

	// Reload value as seen by the counter
	assign reloadValue = {timerHigh, timerLow};

	always_ff @(posedge lspc6M) begin
		if (rst) begin
			timerHigh <= '0;
			timerLow <= '0;
			ctrl <= '0;
			reloadStrobe <= 1'b0;
			ack <= '0;
		end else begin
			// Pulses last one cycle
			reloadStrobe <= 1'b0;
			ack <= '0;
			if (cpuWr.wr) begin
				case (cpuWr.addr)
					`LSPC_REG_TIMER_HIGH: begin
						timerHigh <= cpuWr.data;
					end
					`LSPC_REG_TIMER_LOW: begin
						timerLow <= cpuWr.data;
						// Lower half write arms the reload
						reloadStrobe <= 1'b1;
					end
					`LSPC_REG_CTRL: begin
						ctrl.irqEnable <= cpuWr.data[`LSPC_CTRL_IRQ_EN_BIT];
						ctrl.reloadOnWrite <= cpuWr.data[`LSPC_CTRL_RELOAD_WRITE_BIT];
						ctrl.reloadOnVblank <= cpuWr.data[`LSPC_CTRL_RELOAD_VBLANK_BIT];
						ctrl.reloadOnZero <= cpuWr.data[`LSPC_CTRL_RELOAD_ZERO_BIT];
						ctrl.stopInBorder <= cpuWr.data[`LSPC_CTRL_STOP_BORDER_BIT];
					end
					`LSPC_REG_IRQ_ACK: begin
						// Ack bits are write-one pulses
						ack.timer <= cpuWr.data[`LSPC_ACK_TIMER_BIT];
						ack.vblank <= cpuWr.data[`LSPC_ACK_VBLANK_BIT];
					end
					default: begin
						// Unmapped addresses are ignored
					end
				endcase
			end
		end
	end

	// Reload pulse is a single cycle
	// Back to back low writes from the CPU would break this
	assertStrobeSingle: assert property (
		@(posedge lspc6M) disable iff (rst)
		reloadStrobe |=> !reloadStrobe
	) else $error("reloadStrobe held for two cycles");

endmodule

//--- hdl/lspcTimer.sv
// Programmable 32-bit down-counter with write, vblank and zero reloads and PAL border stop
`timescale 1ns/1ps
`include "lspc_settings.svh"

module lspcTimer import lspcPkg::*; (
	input logic lspc6M,
	input logic rst,
	input logic [31:0] reloadValue,
	input logic reloadStrobe,
	input timerCtrl_t ctrl,
	input rasterPos_t pos,
	input logic palMode,
	output logic timerZero
);

	logic [31:0] count;
	// Line the raster counter shows after the next edge
	logic [8:0] nextLine;
	// Registered count enable
	logic countEn;
	logic load;

	// True for lines above the top border or in the bottom border
	function automatic logic inBorder(input logic [8:0] line);
		return (line < 9'(`LSPC_BORDER_TOP)) || (line >= 9'(`LSPC_BORDER_BOTTOM));
	endfunction

	// Predict the line so the registered enable tracks the current one
	always_comb begin
		nextLine = pos.line;
		if (pos.pixel == 9'(`LSPC_LINE_PIXELS - 1)) begin
			if (pos.line == 9'(`LSPC_FRAME_LINES - 1)) begin
				nextLine = '0;
			end else begin
				nextLine = pos.line + 9'd1;
			end
		end
	end

	// Border stop only applies in PAL mode
	// Held low in reset so no zero pulse leaks out
	always_ff @(posedge lspc6M) begin
		if (rst) begin
			countEn <= 1'b0;
		end else begin
			countEn <= !(ctrl.stopInBorder && palMode && inBorder(nextLine));
		end
	end

	// Zero flag only while counting
	assign timerZero = countEn && (count == 32'd0);

	// Three reload sources merged into one load
	assign load = (reloadStrobe && ctrl.reloadOnWrite)
		|| (pos.vblankStart && ctrl.reloadOnVblank)
		|| (timerZero && ctrl.reloadOnZero);

	always_ff @(posedge lspc6M) begin
		if (rst) begin
			count <= '0;
		end else if (load) begin
			count <= reloadValue;
		end else if (countEn) begin
			// Underflow wraps to all ones in one-shot mode
			count <= count - 32'd1;
		end
	end

	// No zero pulse inside a stopped border region
	// Checked against the live line, not the predicted one
	assertStopHolds: assert property (
		@(posedge lspc6M) disable iff (rst)
		(ctrl.stopInBorder && palMode && inBorder(pos.line)
			&& $past(ctrl.stopInBorder && palMode)) |-> !timerZero
	) else $error("timerZero while stopped in border");

endmodule

//--- hdl/lspcTop.sv
// Raster timer subsystem top, joining register decoder, raster counter, timer and interrupts
`timescale 1ns/1ps

module lspcTop import lspcPkg::*; (
	input logic lspc6M,
	input logic rst,
	input cpuWrite_t cpuWr,
	input logic palMode,
	output logic irqTimer,
	output logic irqVblank
);

	// Register outputs
	logic [31:0] reloadValue;
	logic reloadStrobe;
	timerCtrl_t ctrl;
	irqAck_t ack;

	// Beam position and timer underflow
	rasterPos_t pos;
	logic timerZero;

	lspcRegs regs (
		.lspc6M(lspc6M),
		.rst(rst),
		.cpuWr(cpuWr),
		.reloadValue(reloadValue),
		.reloadStrobe(reloadStrobe),
		.ctrl(ctrl),
		.ack(ack)
	);

	rasterCounter raster (
		.lspc6M(lspc6M),
		.rst(rst),
		.pos(pos)
	);

	lspcTimer timer (
		.lspc6M(lspc6M),
		.rst(rst),
		.reloadValue(reloadValue),
		.reloadStrobe(reloadStrobe),
		.ctrl(ctrl),
		.pos(pos),
		.palMode(palMode),
		.timerZero(timerZero)
	);

	irqController irq (
		.lspc6M(lspc6M),
		.rst(rst),
		.timerZero(timerZero),
		.irqEnable(ctrl.irqEnable),
		.pos(pos),
		.ack(ack),
		.irqTimer(irqTimer),
		.irqVblank(irqVblank)
	);

endmodule

//--- hdl/lspc_settings.svh
// Frame geometry, register map and border limits shared by the raster timer RTL and its testbench
`ifndef LSPC_SETTINGS_SVH
`define LSPC_SETTINGS_SVH

// Frame geometry in pixel clocks and lines
`define LSPC_LINE_PIXELS 384
`define LSPC_FRAME_LINES 264
`define LSPC_VBLANK_LINE 248

// Border lines where the timer may be stopped
`define LSPC_BORDER_TOP 16
`define LSPC_BORDER_BOTTOM 256

// CPU word addresses
`define LSPC_REG_TIMER_HIGH 3'd0
`define LSPC_REG_TIMER_LOW 3'd1
`define LSPC_REG_CTRL 3'd2
`define LSPC_REG_IRQ_ACK 3'd3

// Control word bit positions
`define LSPC_CTRL_IRQ_EN_BIT 4
`define LSPC_CTRL_RELOAD_WRITE_BIT 5
`define LSPC_CTRL_RELOAD_VBLANK_BIT 6
`define LSPC_CTRL_RELOAD_ZERO_BIT 7
`define LSPC_CTRL_STOP_BORDER_BIT 8

// Acknowledge word bit positions
`define LSPC_ACK_TIMER_BIT 1
`define LSPC_ACK_VBLANK_BIT 2

`endif

//--- hdl/rasterCounter.sv
// Free-running pixel and line counters of the video frame, with the vertical blank start pulse
`timescale 1ns/1ps
`include "lspc_settings.svh"

module rasterCounter import lspcPkg::*; (
	input logic lspc6M,
	input logic rst,
	output rasterPos_t pos
);

	// Wrap points of the two counters
	localparam logic [8:0] LAST_PIXEL = 9'(`LSPC_LINE_PIXELS - 1);
	localparam logic [8:0] LAST_LINE = 9'(`LSPC_FRAME_LINES - 1);
	// Line just before vertical blank
	localparam logic [8:0] PRE_VBLANK_LINE = 9'(`LSPC_VBLANK_LINE - 1);

	logic [8:0] pixelCnt;
	logic [8:0] lineCnt;
	logic vblankPulse;

	always_ff @(posedge lspc6M) begin
		if (rst) begin
			pixelCnt <= '0;
			lineCnt <= '0;
			vblankPulse <= 1'b0;
		end else begin
			vblankPulse <= 1'b0;
			if (pixelCnt == LAST_PIXEL) begin
				pixelCnt <= '0;
				// Line steps once per pixel wrap
				if (lineCnt == LAST_LINE) begin
					lineCnt <= '0;
				end else begin
					lineCnt <= lineCnt + 9'd1;
				end
				// Pulse lines up with pixel 0 of the vblank line
				if (lineCnt == PRE_VBLANK_LINE) begin
					vblankPulse <= 1'b1;
				end
			end else begin
				pixelCnt <= pixelCnt + 9'd1;
			end
		end
	end

	// Position bundle for timer and interrupt logic
	assign pos.pixel = pixelCnt;
	assign pos.line = lineCnt;
	assign pos.vblankStart = vblankPulse;

	// Pixel count never leaves the visible line width
	assertPixelRange: assert property (
		@(posedge lspc6M) disable iff (rst)
		pixelCnt < 9'(`LSPC_LINE_PIXELS)
	) else $error("pixel count out of range");

	// Vblank pulse sits at the start of its line
	assertVblankPixel: assert property (
		@(posedge lspc6M) disable iff (rst)
		vblankPulse |-> (pixelCnt == 9'd0) && (lineCnt == 9'(`LSPC_VBLANK_LINE))
	) else $error("vblankStart away from pixel 0 of the vblank line");

endmodule

//--- list.f
+incdir+hdl
hdl/lspcPkg.sv
hdl/lspcRegs.sv
hdl/rasterCounter.sv
hdl/lspcTimer.sv
hdl/irqController.sv
hdl/lspcTop.sv
sim/lspcTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the raster timer testbench with Verilator, runs it and scans the log for a failure

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --top-module lspcTb -f list.f -o lspcSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/lspcSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

grep -qF -- '*** FAILED ***' "$logFile"
grepStatus=$?
if [ $grepStatus -eq 0 ]; then
	echo "Testbench reported a failure, see $logFile"
	exit 1
elif [ $grepStatus -gt 1 ]; then
	echo "Could not search $logFile"
	exit 1
fi
exit 0

//--- sim/lspcTb.sv
// Testbench for the raster timer top, drives CPU writes and checks both irq outputs by assertion
`timescale 1ns/1ps
`include "lspc_settings.svh"

module lspcTb import lspcPkg::*; ();

	// Frame size and the tick at which irqVblank must rise
	localparam int FRAME = `LSPC_LINE_PIXELS * `LSPC_FRAME_LINES;
	// vblankStart at pixel 0 of the vblank line, flag one edge later
	localparam int VB_TICK = `LSPC_VBLANK_LINE * `LSPC_LINE_PIXELS + 1;
	localparam int BORDER_TICKS = `LSPC_BORDER_TOP * `LSPC_LINE_PIXELS;
	// Control and ack data words
	localparam logic [15:0] IRQ_EN = 16'(1 << `LSPC_CTRL_IRQ_EN_BIT);
	localparam logic [15:0] RL_WRITE = 16'(1 << `LSPC_CTRL_RELOAD_WRITE_BIT);
	localparam logic [15:0] RL_VBLANK = 16'(1 << `LSPC_CTRL_RELOAD_VBLANK_BIT);
	localparam logic [15:0] RL_ZERO = 16'(1 << `LSPC_CTRL_RELOAD_ZERO_BIT);
	localparam logic [15:0] STOP_BORDER = 16'(1 << `LSPC_CTRL_STOP_BORDER_BIT);
	localparam logic [15:0] ACK_TIMER = 16'(1 << `LSPC_ACK_TIMER_BIT);
	localparam logic [15:0] ACK_VBLANK = 16'(1 << `LSPC_ACK_VBLANK_BIT);

	logic clk;
	logic rst;
	cpuWrite_t cpuWr;
	logic palMode;
	logic irqTimer;
	logic irqVblank;

	// Model state, tick equals the raster position index after each edge
	int tick;
	int lastWrite;
	// 0 ignore irqTimer, 1 rise only at expTimerRise, 2 must stay low
	int timerMode;
	int expTimerRise;
	int expTimerClear;
	int expVblankClear;
	int errors;
	int timeouts;
	integer seed;

	lspcTop uut (
		.lspc6M(clk),
		.rst(rst),
		.cpuWr(cpuWr),
		.palMode(palMode),
		.irqTimer(irqTimer),
		.irqVblank(irqVblank)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst) begin
			tick <= 0;
		end else begin
			tick <= tick + 1;
		end
	end

	// Nothing pending during or right after reset
	resetQuiet: assert property (@(posedge clk) $past(rst) |-> !irqTimer && !irqVblank)
		else begin
			$display("Fail at %0t: irq output high during reset", $time);
			errors++;
		end

	timerRiseTime: assert property (@(posedge clk) disable iff (rst)
		(timerMode == 1 && $rose(irqTimer)) |-> tick == expTimerRise)
		else begin
			$display("Fail at %0t: irqTimer rose, expected at tick %0d", $time, expTimerRise);
			errors++;
		end

	timerRiseSeen: assert property (@(posedge clk) disable iff (rst)
		(timerMode == 1 && tick == expTimerRise) |-> irqTimer)
		else begin
			$display("Fail at %0t: irqTimer missing at tick %0d", $time, expTimerRise);
			errors++;
		end

	// Gated timer stays quiet
	timerGated: assert property (@(posedge clk) disable iff (rst) (timerMode == 2) |-> !irqTimer)
		else begin
			$display("Fail at %0t: irqTimer high while gated", $time);
			errors++;
		end

	timerAcked: assert property (@(posedge clk) disable iff (rst)
		(tick == expTimerClear) |-> !irqTimer)
		else begin
			$display("Fail at %0t: irqTimer not cleared by ack", $time);
			errors++;
		end

	// Vblank rises once per frame at a fixed position
	vblankRiseTime: assert property (@(posedge clk) disable iff (rst)
		$rose(irqVblank) |-> (tick % FRAME) == VB_TICK)
		else begin
			$display("Fail at %0t: irqVblank rose away from frame tick %0d", $time, VB_TICK);
			errors++;
		end

	vblankRiseSeen: assert property (@(posedge clk) disable iff (rst)
		((tick % FRAME) == VB_TICK) |-> irqVblank)
		else begin
			$display("Fail at %0t: irqVblank missing at vblank start", $time);
			errors++;
		end

	vblankAcked: assert property (@(posedge clk) disable iff (rst)
		(tick == expVblankClear) |-> !irqVblank)
		else begin
			$display("Fail at %0t: irqVblank not cleared by ack", $time);
			errors++;
		end

	// One write cycle, starting and ending on a falling edge
	task automatic writeReg(input logic [2:0] addr, input logic [15:0] data);
		cpuWr.wr = 1'b1;
		cpuWr.addr = addr;
		cpuWr.data = data;
		lastWrite = tick + 1;
		@(negedge clk);
		cpuWr.wr = 1'b0;
	endtask

	// Ack pulse follows the write edge, flag drops one edge later
	task automatic ackTimer();
		writeReg(`LSPC_REG_IRQ_ACK, ACK_TIMER);
		expTimerClear = lastWrite + 1;
		@(negedge clk);
	endtask

	task automatic ackVblank();
		writeReg(`LSPC_REG_IRQ_ACK, ACK_VBLANK);
		expVblankClear = lastWrite + 1;
		@(negedge clk);
	endtask

	task automatic waitTimerIrq(input int limit);
		int n;
		n = 0;
		while (!irqTimer && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!irqTimer) begin
			$display("Timeout: the timer interrupt did not arrive within %0d cycles", limit);
			timeouts++;
		end
	endtask

	task automatic waitVblankIrq();
		int n;
		n = 0;
		while (!irqVblank && n < FRAME + 100) begin
			@(negedge clk);
			n++;
		end
		if (!irqVblank) begin
			$display("Timeout: the vblank interrupt did not arrive within one frame");
			timeouts++;
		end
	endtask

	task automatic waitLineZero();
		int n;
		n = 0;
		while ((tick % FRAME) != 0 && n < FRAME + 10) begin
			@(negedge clk);
			n++;
		end
		if ((tick % FRAME) != 0) begin
			$display("Timeout: the raster never returned to line 0");
			timeouts++;
		end
	endtask

	// Timer values of a few hundred
	function automatic int randomValue();
		return 20 + int'({$random(seed)} % 32'd300);
	endfunction

	// Tick of the next irqVblank rise
	function automatic int nextVblank();
		int v;
		v = tick - (tick % FRAME) + VB_TICK;
		if (v <= tick) begin
			v = v + FRAME;
		end
		return v;
	endfunction

	initial begin
		int n;
		int i;
		int firstRise;
		seed = 32'h6c84_f2f3;
		rst = 1'b1;
		cpuWr = '0;
		palMode = 1'b0;
		errors = 0;
		timeouts = 0;
		lastWrite = 0;
		timerMode = 2;
		expTimerRise = -1;
		expTimerClear = -1;
		expVblankClear = -1;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		repeat (5) @(negedge clk);

		// One-shot, strobe at t+1 loads, zero after N more edges, flag one edge later
		writeReg(`LSPC_REG_CTRL, RL_WRITE | IRQ_EN);
		writeReg(`LSPC_REG_TIMER_HIGH, 16'h0000);
		n = randomValue();
		writeReg(`LSPC_REG_TIMER_LOW, 16'(n));
		expTimerRise = lastWrite + n + 2;
		timerMode = 1;
		waitTimerIrq(n + 20);
		ackTimer();

		// Repeat mode, zero to zero is N+1
		writeReg(`LSPC_REG_CTRL, RL_WRITE | RL_ZERO | IRQ_EN);
		n = randomValue();
		writeReg(`LSPC_REG_TIMER_LOW, 16'(n));
		expTimerRise = lastWrite + n + 2;
		for (i = 0; i < 3; i++) begin
			waitTimerIrq(n + 20);
			ackTimer();
			expTimerRise = expTimerRise + n + 1;
		end

		// Enable clear, countdowns run but no request
		writeReg(`LSPC_REG_CTRL, RL_WRITE | RL_ZERO);
		timerMode = 2;
		n = randomValue();
		writeReg(`LSPC_REG_TIMER_LOW, 16'(n));
		repeat (n + 20) @(negedge clk);
		if (irqVblank) begin
			ackVblank();
		end
		waitVblankIrq();
		firstRise = tick;
		ackVblank();
		waitVblankIrq();
		frameGap: assert (tick - firstRise == FRAME)
			else begin
				$display("Fail at %0t: vblank period %0d, expected %0d", $time,
					tick - firstRise, FRAME);
				errors++;
			end
		ackVblank();

		// Vblank reload, the leftover countdown ends first
		timerMode = 0;
		writeReg(`LSPC_REG_CTRL, RL_VBLANK | IRQ_EN);
		repeat (400) @(negedge clk);
		if (irqTimer) begin
			ackTimer();
		end
		for (i = 0; i < 2; i++) begin
			n = randomValue();
			writeReg(`LSPC_REG_TIMER_LOW, 16'(n));
			// Load on the irqVblank edge, then N edges and one more for the flag
			expTimerRise = nextVblank() + n + 1;
			timerMode = 1;
			waitVblankIrq();
			ackVblank();
			waitTimerIrq(n + 20);
			ackTimer();
		end

		// PAL border stop, load in line 0 and hold until line 16
		timerMode = 0;
		palMode = 1'b1;
		writeReg(`LSPC_REG_CTRL, RL_WRITE | STOP_BORDER | IRQ_EN);
		if (irqTimer) begin
			ackTimer();
		end
		waitLineZero();
		n = randomValue();
		writeReg(`LSPC_REG_TIMER_LOW, 16'(n));
		expTimerRise = lastWrite - (lastWrite % FRAME) + BORDER_TICKS + n + 1;
		timerMode = 1;
		waitTimerIrq(BORDER_TICKS + n + 100);
		ackTimer();
		repeat (5) @(negedge clk);

		$display("lspcTb done with %0d check errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
